/* src/vt52_settings.svh */
// screen geometry and control codes of the VT52 command handler, included by RTL and testbench
`ifndef VT52_SETTINGS_SVH
`define VT52_SETTINGS_SVH

// screen size in character cells
`define ROWS 24
`define COLS 80

// widths of row index, column index and buffer address
`define ROW_BITS 5
`define COL_BITS 7
`define ADDR_BITS 11

// first cell of the last row, and the whole circular buffer
`define LAST_ROW ((`ROWS - 1) * `COLS)
`define BUFFER_SIZE (`ROWS * `COLS)

// byte codes the decoder reacts to
`define CHAR_SPACE 8'h20
`define CHAR_BS 8'h08
`define CHAR_LF 8'h0a
`define CHAR_CR 8'h0d
`define CHAR_ESC 8'h1b
`define CHAR_DEL 8'h7f

// Esc Y row and column bytes carry this bias
`define DCA_OFFSET 8'h20

`endif

/* src/vt52_pkg.sv */
// shared types of the VT52 command handler, imported by every RTL module
`default_nettype none

`include "vt52_settings.svh"

package vt52_pkg;

   typedef logic [7:0] char_t;
   typedef logic [`ROW_BITS-1:0] row_t;
   typedef logic [`COL_BITS-1:0] col_t;
   typedef logic [`ADDR_BITS-1:0] addr_t;
   // one extra bit so row*COLS+first_char does not overflow
   typedef logic [`ADDR_BITS:0] wide_addr_t;

   typedef enum logic [2:0] {
      st_char,
      st_esc,
      st_row,
      st_col,
      st_dca_wait
   } decoder_state_t;

   typedef enum logic [3:0] {
      op_none,
      op_put,
      op_back,
      op_cr,
      op_lf,
      op_up,
      op_down,
      op_right,
      op_left,
      op_home,
      op_erase_eol,
      op_erase_eos
   } cursor_op_t;

   typedef struct packed {
      cursor_op_t op;
      char_t ch;
   } cursor_cmd_t;

   typedef struct packed {
      col_t x;
      row_t y;
   } cursor_pos_t;

   // result of the Esc Y address pipeline
   typedef struct packed {
      row_t row;
      col_t col;
      addr_t row_addr;
   } dca_target_t;

   // inclusive range of cells to fill with ch
   typedef struct packed {
      char_t ch;
      addr_t first;
      addr_t last;
   } write_req_t;

   typedef struct packed {
      char_t ch;
      addr_t addr;
   } char_write_t;

endpackage

`default_nettype wire

/* src/command_decoder.sv */
// escape-sequence FSM, turns input bytes into cursor commands and starts Esc Y addressing
`default_nettype none

`include "vt52_settings.svh"

module command_decoder (
   input wire clk,
   input wire reset,
   input wire vt52_pkg::char_t data,
   input wire valid,
   input wire busy,
   input wire vt52_pkg::cursor_pos_t cursor,
   output logic ready,
   output vt52_pkg::cursor_cmd_t cmd,
   output logic dca_start,
   output vt52_pkg::row_t dca_row,
   output vt52_pkg::col_t dca_col,
   input wire dca_done
);
   import vt52_pkg::*;

   decoder_state_t state;
   decoder_state_t next_state;
   logic consume;
   char_t offset_byte;
   row_t row_in;
   row_t row_q;

   // no input while an erase runs or the Esc Y address is being computed
   assign ready = !busy && (state != st_dca_wait);
   assign consume = valid && ready;

   // coordinate bytes with the bias removed, clamped when out of range
   assign offset_byte = data - char_t'(`DCA_OFFSET);
   assign row_in = (data >= char_t'(`DCA_OFFSET) && data < char_t'(`DCA_OFFSET + `ROWS)) ?
                   row_t'(offset_byte) : cursor.y;
   assign dca_col = (data >= char_t'(`DCA_OFFSET) && data < char_t'(`DCA_OFFSET + `COLS)) ?
                    col_t'(offset_byte) : col_t'(`COLS - 1);
   assign dca_row = row_q;

   always_comb begin
      cmd.op = op_none;
      cmd.ch = data;
      next_state = state;
      dca_start = 1'b0;
      case (state)
         st_char: begin
            if (consume) begin
               if (data >= char_t'(`CHAR_SPACE) && data != char_t'(`CHAR_DEL)) begin
                  cmd.op = op_put;
               end else begin
                  case (data)
                     char_t'(`CHAR_BS): cmd.op = op_back;
                     char_t'(`CHAR_CR): cmd.op = op_cr;
                     char_t'(`CHAR_LF): cmd.op = op_lf;
                     char_t'(`CHAR_ESC): next_state = st_esc;
                     default: ;
                  endcase
               end
            end
         end
         st_esc: begin
            if (consume) begin
               next_state = st_char;
               case (data)
                  "A": cmd.op = op_up;
                  "B": cmd.op = op_down;
                  "C": cmd.op = op_right;
                  "D": cmd.op = op_left;
                  "H": cmd.op = op_home;
                  "K": cmd.op = op_erase_eol;
                  "J": cmd.op = op_erase_eos;
                  "Y": next_state = st_row;
                  // a second escape does not cancel the first
                  char_t'(`CHAR_ESC): next_state = st_esc;
                  default: ;
               endcase
            end
         end
         st_row: begin
            if (consume) begin
               next_state = st_col;
            end
         end
         st_col: begin
            if (consume) begin
               dca_start = 1'b1;
               next_state = st_dca_wait;
            end
         end
         st_dca_wait: begin
            if (dca_done) begin
               next_state = st_char;
            end
         end
         default: next_state = st_char;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_char;
      end else begin
         state <= next_state;
      end
   end

   // Esc Y row is held until the column byte arrives
   always_ff @(posedge clk) begin
      if (state == st_row && consume) begin
         row_q <= row_in;
      end
   end

endmodule

`default_nettype wire

/* src/dca_address.sv */
// two-stage row address pipeline for Esc Y direct cursor addressing
`default_nettype none

`include "vt52_settings.svh"

module dca_address (
   input wire clk,
   input wire reset,
   input wire start,
   input wire vt52_pkg::row_t row,
   input wire vt52_pkg::col_t col,
   input wire vt52_pkg::addr_t first_char,
   output logic done,
   output vt52_pkg::dca_target_t target
);
   import vt52_pkg::*;

   wide_addr_t sum_q;
   row_t row_q;
   col_t col_q;
   logic stage_valid;

   // stage one, unwrapped row start relative to the first displayed cell
   always_ff @(posedge clk) begin
      sum_q <= wide_addr_t'(row) * wide_addr_t'(`COLS) + wide_addr_t'(first_char);
      row_q <= row;
      col_q <= col;
   end

   // stage two, fold back into the circular buffer
   always_ff @(posedge clk) begin
      target.row <= row_q;
      target.col <= col_q;
      target.row_addr <= (sum_q > wide_addr_t'(`LAST_ROW)) ?
                         addr_t'(sum_q - wide_addr_t'(`BUFFER_SIZE)) : addr_t'(sum_q);
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         stage_valid <= 1'b0;
         done <= 1'b0;
      end else begin
         stage_valid <= start;
         done <= stage_valid;
      end
   end

endmodule

`default_nettype wire

/* src/cursor_tracker.sv */
// cursor and scroll state, applies decoded commands and issues buffer write requests
`default_nettype none

`include "vt52_settings.svh"

module cursor_tracker (
   input wire clk,
   input wire reset,
   input wire vt52_pkg::cursor_cmd_t cmd,
   input wire dca_done,
   input wire vt52_pkg::dca_target_t target,
   output vt52_pkg::cursor_pos_t cursor,
   output logic cursor_wen,
   output vt52_pkg::addr_t first_char,
   output logic first_char_wen,
   output vt52_pkg::write_req_t write_req,
   output logic req_valid
);
   import vt52_pkg::*;

   addr_t row_addr;
   addr_t char_addr;
   addr_t row_down;
   addr_t row_up;
   addr_t x_addr;
   logic at_left;
   logic at_right;
   logic at_top;
   logic at_bottom;

   // neighbouring row addresses in the circular buffer
   assign row_down = (row_addr == addr_t'(`LAST_ROW)) ? '0 : row_addr + addr_t'(`COLS);
   assign row_up = (row_addr == '0) ? addr_t'(`LAST_ROW) : row_addr - addr_t'(`COLS);
   assign x_addr = addr_t'(cursor.x);

   assign at_left = (cursor.x == '0);
   assign at_right = (cursor.x == col_t'(`COLS - 1));
   assign at_top = (cursor.y == '0);
   assign at_bottom = (cursor.y == row_t'(`ROWS - 1));

   always_ff @(posedge clk) begin
      if (reset) begin
         cursor <= '0;
         cursor_wen <= 1'b0;
         first_char <= '0;
         first_char_wen <= 1'b0;
         row_addr <= '0;
         char_addr <= '0;
         req_valid <= 1'b0;
      end else begin
         cursor_wen <= 1'b0;
         first_char_wen <= 1'b0;
         req_valid <= 1'b0;
         if (dca_done) begin
            cursor.x <= target.col;
            cursor.y <= target.row;
            row_addr <= target.row_addr;
            char_addr <= target.row_addr + addr_t'(target.col);
            cursor_wen <= (target.col != cursor.x) || (target.row != cursor.y);
         end else begin
            case (cmd.op)
               op_put: begin
                  write_req <= '{ch: cmd.ch, first: char_addr, last: char_addr};
                  req_valid <= 1'b1;
                  // no auto wrap, the last column is overwritten
                  if (!at_right) begin
                     cursor.x <= cursor.x + col_t'(1);
                     char_addr <= char_addr + addr_t'(1);
                     cursor_wen <= 1'b1;
                  end
               end
               op_back, op_left: begin
                  if (!at_left) begin
                     cursor.x <= cursor.x - col_t'(1);
                     char_addr <= char_addr - addr_t'(1);
                     cursor_wen <= 1'b1;
                  end
               end
               op_right: begin
                  if (!at_right) begin
                     cursor.x <= cursor.x + col_t'(1);
                     char_addr <= char_addr + addr_t'(1);
                     cursor_wen <= 1'b1;
                  end
               end
               op_cr: begin
                  if (!at_left) begin
                     cursor.x <= '0;
                     char_addr <= row_addr;
                     cursor_wen <= 1'b1;
                  end
               end
               op_lf: begin
                  row_addr <= row_down;
                  char_addr <= row_down + x_addr;
                  if (!at_bottom) begin
                     cursor.y <= cursor.y + row_t'(1);
                     cursor_wen <= 1'b1;
                  end else begin
                     // scroll, the old top line becomes the new bottom line
                     first_char <= (first_char == addr_t'(`LAST_ROW)) ?
                                   '0 : first_char + addr_t'(`COLS);
                     first_char_wen <= 1'b1;
                     write_req <= '{ch: char_t'(`CHAR_SPACE), first: first_char,
                                    last: first_char + addr_t'(`COLS - 1)};
                     req_valid <= 1'b1;
                  end
               end
               op_down: begin
                  if (!at_bottom) begin
                     cursor.y <= cursor.y + row_t'(1);
                     row_addr <= row_down;
                     char_addr <= row_down + x_addr;
                     cursor_wen <= 1'b1;
                  end
               end
               op_up: begin
                  if (!at_top) begin
                     cursor.y <= cursor.y - row_t'(1);
                     row_addr <= row_up;
                     char_addr <= row_up + x_addr;
                     cursor_wen <= 1'b1;
                  end
               end
               op_home: begin
                  cursor <= '0;
                  row_addr <= first_char;
                  char_addr <= first_char;
                  cursor_wen <= !at_left || !at_top;
               end
               op_erase_eol: begin
                  write_req <= '{ch: char_t'(`CHAR_SPACE), first: char_addr,
                                 last: row_addr + addr_t'(`COLS - 1)};
                  req_valid <= 1'b1;
               end
               op_erase_eos: begin
                  // the screen ends just before the first displayed cell
                  write_req <= '{ch: char_t'(`CHAR_SPACE), first: char_addr,
                                 last: (first_char == '0) ? addr_t'(`BUFFER_SIZE - 1) :
                                       first_char - addr_t'(1)};
                  req_valid <= 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

/* src/screen_writer.sv */
// character buffer write port, one write per cycle over a wrapping address range
`default_nettype none

`include "vt52_settings.svh"

module screen_writer (
   input wire clk,
   input wire reset,
   input wire vt52_pkg::write_req_t write_req,
   input wire req_valid,
   output vt52_pkg::char_write_t char_write,
   output logic char_wen,
   output logic busy
);
   import vt52_pkg::*;

   addr_t last_q;
   addr_t next_addr;
   logic active;

   assign next_addr = (char_write.addr == addr_t'(`BUFFER_SIZE - 1)) ?
                      '0 : char_write.addr + addr_t'(1);

   // a range request blocks input from its arrival until the last write goes out
   assign busy = (req_valid && (write_req.first != write_req.last)) || active;

   always_ff @(posedge clk) begin
      if (reset) begin
         char_write <= '0;
         char_wen <= 1'b0;
         active <= 1'b0;
      end else begin
         char_wen <= 1'b0;
         if (req_valid) begin
            char_write <= '{ch: write_req.ch, addr: write_req.first};
            char_wen <= 1'b1;
            active <= (write_req.first != write_req.last);
         end else if (active) begin
            char_write.addr <= next_addr;
            char_wen <= 1'b1;
            active <= (next_addr != last_q);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req_valid) begin
         last_q <= write_req.last;
      end
   end

endmodule

`default_nettype wire

/* src/vt52_command_handler.sv */
// top level of the VT52 command handler, connects decoder, tracker, Esc Y pipeline and writer
`default_nettype none

module vt52_command_handler (
   input wire clk,
   input wire reset,
   input wire vt52_pkg::char_t data,
   input wire valid,
   output logic ready,
   output vt52_pkg::char_write_t char_write,
   output logic char_wen,
   output vt52_pkg::cursor_pos_t cursor,
   output logic cursor_wen,
   output vt52_pkg::addr_t first_char,
   output logic first_char_wen
);
   import vt52_pkg::*;

   cursor_cmd_t cmd;
   logic busy;
   logic dca_start;
   row_t dca_row;
   col_t dca_col;
   logic dca_done;
   dca_target_t target;
   write_req_t write_req;
   logic req_valid;

   command_decoder command_decoder_i (
      .clk(clk),
      .reset(reset),
      .data(data),
      .valid(valid),
      .busy(busy),
      .cursor(cursor),
      .ready(ready),
      .cmd(cmd),
      .dca_start(dca_start),
      .dca_row(dca_row),
      .dca_col(dca_col),
      .dca_done(dca_done)
   );

   dca_address dca_address_i (
      .clk(clk),
      .reset(reset),
      .start(dca_start),
      .row(dca_row),
      .col(dca_col),
      .first_char(first_char),
      .done(dca_done),
      .target(target)
   );

   cursor_tracker cursor_tracker_i (
      .clk(clk),
      .reset(reset),
      .cmd(cmd),
      .dca_done(dca_done),
      .target(target),
      .cursor(cursor),
      .cursor_wen(cursor_wen),
      .first_char(first_char),
      .first_char_wen(first_char_wen),
      .write_req(write_req),
      .req_valid(req_valid)
   );

   screen_writer screen_writer_i (
      .clk(clk),
      .reset(reset),
      .write_req(write_req),
      .req_valid(req_valid),
      .char_write(char_write),
      .char_wen(char_wen),
      .busy(busy)
   );

endmodule

`default_nettype wire

/* verification/vt52_model.svh */
// reference model of the VT52 command handler and the stimulus LFSR, included in the testbench module
`ifndef VT52_MODEL_SVH
`define VT52_MODEL_SVH

typedef enum {mode_text, mode_esc, mode_row, mode_col} model_mode_t;

logic [31:0] lfsr_state = 32'h36611f14;

// shadow state, addresses kept as plain integers
int m_x;
int m_y;
int m_row_addr;
int m_char_addr;
int m_first;
int m_dca_row;
model_mode_t m_mode;

// expected output events in the order the DUT must produce them
char_write_t exp_writes[$];
cursor_pos_t exp_cursor[$];
addr_t exp_first[$];

// x^32 + x^22 + x^2 + x + 1, one step for every bit taken
function automatic int take_bits(input int n);
   int value;
   int i;
   logic fb;
   value = 0;
   for (i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      value = (value << 1) | int'(fb);
   end
   return value;
endfunction

function automatic void model_reset();
   m_x = 0;
   m_y = 0;
   m_row_addr = 0;
   m_char_addr = 0;
   m_first = 0;
   m_dca_row = 0;
   m_mode = mode_text;
   exp_writes.delete();
   exp_cursor.delete();
   exp_first.delete();
endfunction

// a cursor_wen is only expected when the position really changes
function automatic void model_cursor(input int x, input int y);
   cursor_pos_t c;
   if (x != m_x || y != m_y) begin
      c.x = col_t'(x);
      c.y = row_t'(y);
      exp_cursor.push_back(c);
   end
   m_x = x;
   m_y = y;
endfunction

// inclusive range, the buffer is circular
function automatic void expect_fill(input int ch, input int first, input int last);
   char_write_t w;
   int a;
   a = first;
   w.ch = char_t'(ch);
   w.addr = addr_t'(a);
   exp_writes.push_back(w);
   while (a != last) begin
      a = (a + 1) % `BUFFER_SIZE;
      w.addr = addr_t'(a);
      exp_writes.push_back(w);
   end
endfunction

function automatic void model_row_step(input int delta, input int new_y);
   m_row_addr = (m_row_addr + `BUFFER_SIZE + delta) % `BUFFER_SIZE;
   m_char_addr = m_row_addr + m_x;
   model_cursor(m_x, new_y);
endfunction

function automatic void model_line_feed();
   if (m_y < `ROWS - 1) begin
      model_row_step(`COLS, m_y + 1);
   end else begin
      // old top line is blanked and becomes the new bottom line
      expect_fill(`CHAR_SPACE, m_first, m_first + `COLS - 1);
      m_first = (m_first + `COLS) % `BUFFER_SIZE;
      exp_first.push_back(addr_t'(m_first));
      model_row_step(`COLS, m_y);
   end
endfunction

function automatic void model_escape(input char_t b);
   m_mode = mode_text;
   case (b)
      "A": if (m_y > 0) model_row_step(-`COLS, m_y - 1);
      "B": if (m_y < `ROWS - 1) model_row_step(`COLS, m_y + 1);
      "C": if (m_x < `COLS - 1) begin
         m_char_addr++;
         model_cursor(m_x + 1, m_y);
      end
      "D": if (m_x > 0) begin
         m_char_addr--;
         model_cursor(m_x - 1, m_y);
      end
      "H": begin
         m_row_addr = m_first;
         m_char_addr = m_first;
         model_cursor(0, 0);
      end
      "K": expect_fill(`CHAR_SPACE, m_char_addr, m_row_addr + `COLS - 1);
      "J": expect_fill(`CHAR_SPACE, m_char_addr,
                       (m_first == 0) ? `BUFFER_SIZE - 1 : m_first - 1);
      "Y": m_mode = mode_row;
      `CHAR_ESC: m_mode = mode_esc;
      default: ;
   endcase
endfunction

function automatic void model_byte(input char_t b);
   int v;
   v = int'(b) - int'(`DCA_OFFSET);
   case (m_mode)
      mode_text: begin
         if (b >= `CHAR_SPACE && b != `CHAR_DEL) begin
            expect_fill(int'(b), m_char_addr, m_char_addr);
            if (m_x < `COLS - 1) begin
               m_char_addr++;
               model_cursor(m_x + 1, m_y);
            end
         end else if (b == `CHAR_BS && m_x > 0) begin
            m_char_addr--;
            model_cursor(m_x - 1, m_y);
         end else if (b == `CHAR_CR) begin
            m_char_addr = m_row_addr;
            model_cursor(0, m_y);
         end else if (b == `CHAR_LF) begin
            model_line_feed();
         end else if (b == `CHAR_ESC) begin
            m_mode = mode_esc;
         end
      end
      mode_esc: model_escape(b);
      mode_row: begin
         m_dca_row = (v >= 0 && v < `ROWS) ? v : m_y;
         m_mode = mode_col;
      end
      default: begin
         // rows count from the first displayed line
         m_row_addr = (m_first + m_dca_row * `COLS) % `BUFFER_SIZE;
         v = (v >= 0 && v < `COLS) ? v : `COLS - 1;
         m_char_addr = m_row_addr + v;
         model_cursor(v, m_dca_row);
         m_mode = mode_text;
      end
   endcase
endfunction

`endif

/* verification/vt52_tb.sv */
// testbench of the VT52 command handler, a random byte stream checked against a reference model
`default_nettype none

`include "vt52_settings.svh"

module vt52_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import vt52_pkg::*;

   localparam int TIMEOUT = 4000;

   logic clk;
   logic reset;
   char_t data;
   logic valid;
   logic ready;
   char_write_t char_write;
   logic char_wen;
   cursor_pos_t cursor;
   logic cursor_wen;
   addr_t first_char;
   logic first_char_wen;

   int errors;
   int test_errors;
   int tests_run;
   int tests_failed;
   logic timed_out;

   `include "vt52_model.svh"

   vt52_command_handler vt52_command_handler_i (
      .clk(clk),
      .reset(reset),
      .data(data),
      .valid(valid),
      .ready(ready),
      .char_write(char_write),
      .char_wen(char_wen),
      .cursor(cursor),
      .cursor_wen(cursor_wen),
      .first_char(first_char),
      .first_char_wen(first_char_wen)
   );

   always #10 clk = ~clk;

   function automatic void report_mismatch(input string name, input int expected,
                                           input int actual);
      $display("FAILED %s expected %h got %h", name, expected, actual);
      errors++;
      test_errors++;
   endfunction

   function automatic void report_problem(input string msg);
      $display("error: %s", msg);
      errors++;
      test_errors++;
   endfunction

   // advance to the next falling edge and match any enable pulse against the model
   task automatic next_cycle();
      char_write_t w;
      cursor_pos_t c;
      addr_t f;
      @(negedge clk);
      if (char_wen && exp_writes.size() == 0) begin
         report_problem($sformatf("unexpected write of %h at address %h",
                                  char_write.ch, char_write.addr));
      end else if (char_wen) begin
         w = exp_writes.pop_front();
         if (char_write.addr != w.addr)
            report_mismatch("char_write.addr", int'(w.addr), int'(char_write.addr));
         if (char_write.ch != w.ch)
            report_mismatch("char_write.ch", int'(w.ch), int'(char_write.ch));
      end
      if (cursor_wen && exp_cursor.size() == 0) begin
         report_problem($sformatf("unexpected cursor move to %0d,%0d", cursor.x, cursor.y));
      end else if (cursor_wen) begin
         c = exp_cursor.pop_front();
         if (cursor.x != c.x) report_mismatch("cursor.x", int'(c.x), int'(cursor.x));
         if (cursor.y != c.y) report_mismatch("cursor.y", int'(c.y), int'(cursor.y));
      end
      if (first_char_wen && exp_first.size() == 0) begin
         report_problem("unexpected first_char update");
      end else if (first_char_wen) begin
         f = exp_first.pop_front();
         if (first_char != f) report_mismatch("first_char", int'(f), int'(first_char));
      end
   endtask

   task automatic wait_ready();
      int n;
      n = 0;
      while (!ready && !timed_out) begin
         if (n == TIMEOUT) begin
            report_problem("timeout, ready stayed low");
            timed_out = 1'b1;
         end else begin
            next_cycle();
            n++;
         end
      end
   endtask

   task automatic send_byte(input char_t b);
      wait_ready();
      if (!timed_out) begin
         data = b;
         valid = 1'b1;
         model_byte(b);
         next_cycle();
         valid = 1'b0;
      end
   endtask

   task automatic send_dca(input char_t row_byte, input char_t col_byte);
      send_byte(`CHAR_ESC);
      send_byte("Y");
      send_byte(row_byte);
      send_byte(col_byte);
      if (ready && !timed_out) report_problem("ready high right after the Esc Y column byte");
   endtask

   // ready must stay low until the last write of a range is out
   task automatic check_blocked_erase();
      int n;
      n = 0;
      while (!timed_out && exp_writes.size() > 0) begin
         if (ready && (n > 0 || exp_writes.size() > 1))
            report_problem("ready high while erase writes are pending");
         if (n == TIMEOUT) begin
            report_problem("timeout, erase writes never finished");
            timed_out = 1'b1;
         end else begin
            next_cycle();
            n++;
         end
      end
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (!timed_out && (exp_writes.size() > 0 || exp_cursor.size() > 0 ||
                            exp_first.size() > 0 || !ready)) begin
         if (n == TIMEOUT) begin
            report_problem("timeout, expected output events never came");
            timed_out = 1'b1;
         end else begin
            next_cycle();
            n++;
         end
      end
      // quiet cycles catch stray enable pulses
      repeat (4) next_cycle();
      if (cursor.x != col_t'(m_x)) report_mismatch("cursor.x", m_x, int'(cursor.x));
      if (cursor.y != row_t'(m_y)) report_mismatch("cursor.y", m_y, int'(cursor.y));
      if (first_char != addr_t'(m_first))
         report_mismatch("first_char", m_first, int'(first_char));
   endtask

   task automatic end_test(input string name);
      drain();
      tests_run++;
      if (test_errors == 0) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", tests_run, name, test_errors);
      end
      test_errors = 0;
   endtask

   function automatic char_t random_printable();
      return char_t'(32 + take_bits(7) % 95);
   endfunction

   // about half the row bytes and a fifth of the column bytes are off screen
   function automatic char_t random_row_byte();
      return char_t'(16 + take_bits(6) % 48);
   endfunction

   function automatic char_t random_col_byte();
      return char_t'(16 + take_bits(7) % 104);
   endfunction

   function automatic char_t escape_letter(input int idx);
      case (idx)
         0: return "A";
         1: return "B";
         2: return "C";
         3: return "D";
         4: return "H";
         5: return "Q";
         6: return `CHAR_ESC;
         7: return "K";
         8: return "J";
         default: return "Y";
      endcase
   endfunction

   initial begin
      int i;
      int j;
      int len;
      int pick;
      clk = 1'b0;
      reset = 1'b1;
      data = '0;
      valid = 1'b0;
      errors = 0;
      test_errors = 0;
      tests_run = 0;
      tests_failed = 0;
      timed_out = 1'b0;
      model_reset();
      repeat (5) @(negedge clk);
      reset = 1'b0;

      if (ready !== 1'b1) report_mismatch("ready", 1, int'(ready));
      if (char_wen !== 1'b0) report_mismatch("char_wen", 0, int'(char_wen));
      if (cursor_wen !== 1'b0) report_mismatch("cursor_wen", 0, int'(cursor_wen));
      if (first_char_wen !== 1'b0) report_mismatch("first_char_wen", 0, int'(first_char_wen));
      end_test("reset state");

      // long runs pile up in the last column
      for (i = 0; i < 4 && !timed_out; i++) begin
         send_byte(`CHAR_CR);
         send_byte(`CHAR_LF);
         len = 70 + take_bits(6);
         for (j = 0; j < len; j++) send_byte(random_printable());
      end
      if (!timed_out) end_test("printable runs");

      for (i = 0; i < 300 && !timed_out; i++) begin
         pick = take_bits(3);
         if (pick == 0) begin
            send_byte(`CHAR_BS);
         end else if (pick == 1) begin
            send_byte(`CHAR_CR);
         end else begin
            send_byte(`CHAR_ESC);
            send_byte(escape_letter(take_bits(3) % 7));
         end
      end
      if (!timed_out) end_test("cursor moves");

      send_dca(char_t'(`DCA_OFFSET + `ROWS - 1), random_col_byte());
      for (i = 0; i < 30 && !timed_out; i++) begin
         send_byte(`CHAR_LF);
         check_blocked_erase();
         if (i % 7 == 0) send_byte(random_printable());
      end
      if (!timed_out) end_test("line feed scroll");

      // one scroll per round, first_char passes through 0 on the way
      for (i = 0; i < 20 && !timed_out; i++) begin
         send_dca(char_t'(`DCA_OFFSET + `ROWS - 1), random_col_byte());
         send_byte(`CHAR_LF);
         check_blocked_erase();
         send_dca(random_row_byte(), random_col_byte());
         send_byte(`CHAR_ESC);
         if (i % 2 == 0) begin
            send_byte("K");
         end else begin
            send_byte("J");
         end
         check_blocked_erase();
      end
      if (!timed_out) end_test("erase ranges");

      for (i = 0; i < 40 && !timed_out; i++) begin
         send_dca(random_row_byte(), random_col_byte());
         send_byte(random_printable());
         if (take_bits(2) == 0) begin
            send_dca(char_t'(`DCA_OFFSET + `ROWS - 1), random_col_byte());
            send_byte(`CHAR_LF);
         end
      end
      if (!timed_out) end_test("direct cursor addressing");

      for (i = 0; i < 400 && !timed_out; i++) begin
         pick = take_bits(4);
         if (pick < 8) begin
            send_byte(random_printable());
         end else if (pick == 8) begin
            send_byte(`CHAR_BS);
         end else if (pick == 9) begin
            send_byte(`CHAR_CR);
         end else if (pick < 12) begin
            send_byte(`CHAR_LF);
         end else if (pick < 15) begin
            send_byte(`CHAR_ESC);
            send_byte(escape_letter(take_bits(4) % 10));
         end else begin
            send_byte(random_row_byte());
         end
      end
      if (!timed_out) end_test("mixed stream");

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
+incdir+src
+incdir+verification
src/vt52_pkg.sv
src/command_decoder.sv
src/dca_address.sv
src/cursor_tracker.sv
src/screen_writer.sv
src/vt52_command_handler.sv
verification/vt52_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module vt52_tb -o vt52_sim
./obj_dir/vt52_sim > sim.log
cat sim.log

if grep -qx "all tests passed" sim.log; then
   exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
